// ==== flist.f ====
hdl/sw_score_pkg.sv
hdl/avm_map_pkg.sv
hdl/sw_cell.sv
hdl/sw_core.sv
hdl/sw_wrapper.sv
verif/tb_clkgen.sv
verif/avm_uart_model.sv
verif/sw_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -Wno-fatal
TB_TOP      = sw_tb
RTL_TOP     = sw_wrapper
FLIST       = flist.f
BUILD_DIR   = obj_dir
LOG         = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/sw_tb.sv ====
`timescale 1ns/100ps

module sw_tb
    import sw_score_pkg::*;
    import avm_map_pkg::*;
();

    localparam int REF_LEN     = 16;
    localparam int READ_LEN    = 16;
    localparam int IDX_W       = $clog2((REF_LEN > READ_LEN) ? REF_LEN : READ_LEN);
    localparam int JOBS        = 14;
    localparam int WATCHDOG_NS = JOBS * (REF_LEN * READ_LEN + 200) * 4;

    logic        avm_clk, avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read, avm_write, avm_waitrequest;
    logic [31:0] avm_readdata, avm_writedata;
    logic [3:0]  wait_states, rx_delay, tx_delay;

    logic [15:0]           lfsr_r;
    logic [2*REF_LEN-1:0]  rand_ref [5];
    logic [2*READ_LEN-1:0] rand_read [5];
    int                    errors, checks, tests;

    tb_clkgen u_clkgen (
        .o_clk (avm_clk),
        .o_rst (avm_rst)
    );

    avm_uart_model u_uart (
        .i_clk             (avm_clk),
        .i_rst             (avm_rst),
        .i_avm_address     (avm_address),
        .i_avm_read        (avm_read),
        .i_avm_write       (avm_write),
        .i_avm_writedata   (avm_writedata),
        .o_avm_readdata    (avm_readdata),
        .o_avm_waitrequest (avm_waitrequest),
        .i_wait_states     (wait_states),
        .i_rx_delay        (rx_delay),
        .i_tx_delay        (tx_delay)
    );

    sw_wrapper #(
        .REF_LEN  (REF_LEN),
        .READ_LEN (READ_LEN)
    ) dut (
        .avm_clk           (avm_clk),
        .avm_rst           (avm_rst),
        .o_avm_address     (avm_address),
        .o_avm_read        (avm_read),
        .o_avm_write       (avm_write),
        .i_avm_readdata    (avm_readdata),
        .o_avm_writedata   (avm_writedata),
        .i_avm_waitrequest (avm_waitrequest)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_r = lfsr_next(lfsr_r);
            v      = {v[62:0], lfsr_r[0]};
        end
    endtask

    function automatic int clip_score(input int v);
        if (v > int'(SCORE_MAX))
            return int'(SCORE_MAX);
        if (v < int'(SCORE_MIN))
            return int'(SCORE_MIN);
        return v;
    endfunction

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // software local alignment, affine gaps, first maximum in row-major order
    function automatic void align_ref(input logic [2*REF_LEN-1:0] ref_seq,
                                      input logic [2*READ_LEN-1:0] rd_seq,
                                      output int best, output int best_row,
                                      output int best_col);
        int h [READ_LEN+1][REF_LEN+1];
        int e [READ_LEN+1][REF_LEN+1];
        int f [READ_LEN+1][REF_LEN+1];
        int sub;
        best     = 0;
        best_row = 0;
        best_col = 0;
        for (int i = 0; i <= READ_LEN; i++) begin
            for (int j = 0; j <= REF_LEN; j++) begin
                h[i][j] = 0;
                e[i][j] = int'(SCORE_MIN);
                f[i][j] = int'(SCORE_MIN);
            end
        end
        for (int i = 1; i <= READ_LEN; i++) begin
            for (int j = 1; j <= REF_LEN; j++) begin
                if (ref_seq[2*(REF_LEN-j) +: 2] == rd_seq[2*(READ_LEN-i) +: 2])
                    sub = int'(MATCH_SCORE);
                else
                    sub = int'(MISMATCH_SCORE);
                e[i][j] = clip_score(larger(h[i][j-1] + int'(GAP_OPEN),
                                            e[i][j-1] + int'(GAP_EXTEND)));
                f[i][j] = clip_score(larger(h[i-1][j] + int'(GAP_OPEN),
                                            f[i-1][j] + int'(GAP_EXTEND)));
                h[i][j] = larger(larger(0, clip_score(h[i-1][j-1] + sub)),
                                 larger(e[i][j], f[i][j]));
                if (h[i][j] > best) begin
                    best     = h[i][j];
                    best_row = i - 1;
                    best_col = j - 1;
                end
            end
        end
    endfunction

    task automatic compare_score(input score_t got, input score_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s score is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_index(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_address(input logic [4:0] got, input logic [4:0] exp,
                                   input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s address is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t: %s sent %0d bytes, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start)
            $display("test %-14s ok", name);
        else
            $display("test %-14s FAILED with %0d errors", name, errors - err_start);
    endtask

    task automatic send_job(input logic [2*REF_LEN-1:0] ref_seq,
                            input logic [2*READ_LEN-1:0] rd_seq);
        for (int k = 0; k < REF_LEN / 4; k++)
            u_uart.push_rx(ref_seq[2*REF_LEN-1-8*k -: 8]);
        for (int k = 0; k < READ_LEN / 4; k++)
            u_uart.push_rx(rd_seq[2*READ_LEN-1-8*k -: 8]);
    endtask

    task automatic check_result(input int exp_score, input int exp_row, input int exp_col,
                                input string what);
        logic [7:0]  b [RESULT_BYTES];
        logic [15:0] exp_word;
        while (u_uart.tx_count() < RESULT_BYTES)
            @(negedge avm_clk);
        // a stray fifth byte would show up here
        repeat (8) @(negedge avm_clk);
        compare_count(u_uart.tx_count(), RESULT_BYTES, what);
        for (int k = 0; k < RESULT_BYTES; k++)
            u_uart.pop_tx(b[k]);
        // two's complement score widened to the two score bytes
        exp_word = 16'(exp_score);
        compare_byte(b[0], exp_word[15:8], {what, " score high byte"});
        compare_score(score_t'({b[0], b[1]}), score_t'(exp_score), what);
        compare_index(IDX_W'(b[2]), IDX_W'(exp_row), {what, " row"});
        compare_index(IDX_W'(b[3]), IDX_W'(exp_col), {what, " column"});
    endtask

    task automatic check_job(input logic [2*REF_LEN-1:0] ref_seq,
                             input logic [2*READ_LEN-1:0] rd_seq, input string what);
        int exp_score, exp_row, exp_col;
        align_ref(ref_seq, rd_seq, exp_score, exp_row, exp_col);
        check_result(exp_score, exp_row, exp_col, what);
    endtask

    task automatic test_reset();
        int err_start;
        err_start = errors;
        @(negedge avm_clk);
        compare_flag(avm_read, 1'b1, "read after reset");
        compare_flag(avm_write, 1'b0, "write after reset");
        compare_address(avm_address, STATUS_ADDR, "reset");
        // nothing in the RX queue, so nothing may be written
        repeat (20) begin
            @(negedge avm_clk);
            compare_flag(avm_write, 1'b0, "write while idle");
        end
        compare_count(u_uart.tx_count(), 0, "idle wrapper");
        report_test("reset", err_start);
    endtask

    task automatic test_identical();
        int err_start;
        err_start = errors;
        send_job(32'h1BE4_1BE4, 32'h1BE4_1BE4);
        check_result(16 * int'(MATCH_SCORE), 15, 15, "identical");
        report_test("identical", err_start);
    endtask

    task automatic test_directed();
        int err_start;
        err_start = errors;
        // read has one inserted base and one mismatch against the reference
        send_job(32'h1BE4_1BE4, 32'h1BE1_05F9);
        check_job(32'h1BE4_1BE4, 32'h1BE1_05F9, "directed");
        report_test("directed", err_start);
    endtask

    task automatic test_random();
        int err_start;
        logic [63:0] v;
        err_start = errors;
        for (int n = 0; n < 5; n++) begin
            take_bits(2 * REF_LEN, v);
            rand_ref[n] = (2*REF_LEN)'(v);
            take_bits(2 * READ_LEN, v);
            rand_read[n] = (2*READ_LEN)'(v);
            send_job(rand_ref[n], rand_read[n]);
            check_job(rand_ref[n], rand_read[n], $sformatf("random job %0d", n));
        end
        report_test("random", err_start);
    endtask

    task automatic test_backpressure();
        int err_start;
        logic [63:0] v;
        err_start = errors;
        for (int n = 0; n < 5; n++) begin
            @(posedge avm_clk);
            take_bits(2, v);
            wait_states <= 4'(v[1:0]);
            take_bits(3, v);
            rx_delay <= 4'(v[2:0]);
            take_bits(3, v);
            tx_delay <= 4'(v[2:0]);
            send_job(rand_ref[n], rand_read[n]);
            check_job(rand_ref[n], rand_read[n], $sformatf("stalled job %0d", n));
        end
        @(posedge avm_clk);
        wait_states <= '0;
        rx_delay    <= '0;
        tx_delay    <= '0;
        report_test("backpressure", err_start);
    endtask

    task automatic test_no_match();
        int err_start;
        err_start = errors;
        // second job queued behind the first
        send_job(32'h0000_0000, 32'hFFFF_FFFF);
        send_job(32'h1BE4_1BE4, 32'h1BE1_05F9);
        check_result(0, 0, 0, "no match");
        check_job(32'h1BE4_1BE4, 32'h1BE1_05F9, "job after no match");
        report_test("no_match", err_start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT did not return all results in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        lfsr_r      = 16'd49954;
        wait_states <= '0;
        rx_delay    <= '0;
        tx_delay    <= '0;
        wait (avm_rst === 1'b1);
        wait (avm_rst === 1'b0);
        test_reset();
        test_identical();
        test_directed();
        test_random();
        test_backpressure();
        test_no_match();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== verif/avm_uart_model.sv ====
`timescale 1ns/100ps

module avm_uart_model
    import avm_map_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [4:0]  i_avm_address,
    input  logic        i_avm_read,
    input  logic        i_avm_write,
    input  logic [31:0] i_avm_writedata,
    output logic [31:0] o_avm_readdata,
    output logic        o_avm_waitrequest,
    input  logic [3:0]  i_wait_states,
    input  logic [3:0]  i_rx_delay,
    input  logic [3:0]  i_tx_delay
);

    logic [7:0] rx_q [$];
    logic [7:0] tx_q [$];
    logic [7:0] rx_byte;
    int         wait_cnt;
    // cycles since the last byte moved in each direction
    int         rx_idle;
    int         tx_idle;

    task automatic push_rx(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    function automatic int tx_count();
        return tx_q.size();
    endfunction

    task automatic pop_tx(output logic [7:0] b);
        b = tx_q.pop_front();
    endtask

    always @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_avm_waitrequest <= 1'b1;
            o_avm_readdata    <= '0;
            wait_cnt          <= 0;
            rx_idle           <= 0;
            tx_idle           <= 0;
        end else begin
            rx_idle <= rx_idle + 1;
            tx_idle <= tx_idle + 1;
            if (!o_avm_waitrequest) begin
                // access completed on this edge
                o_avm_waitrequest <= 1'b1;
                wait_cnt          <= 0;
            end else if (i_avm_read || i_avm_write) begin
                if (wait_cnt < int'(i_wait_states)) begin
                    wait_cnt <= wait_cnt + 1;
                end else begin
                    o_avm_waitrequest <= 1'b0;
                    o_avm_readdata    <= '0;
                    if (i_avm_write) begin
                        if (i_avm_address == TX_ADDR) begin
                            tx_q.push_back(i_avm_writedata[7:0]);
                            tx_idle <= 0;
                        end
                    end else if (i_avm_address == RX_ADDR && rx_q.size() != 0) begin
                        rx_byte = rx_q.pop_front();
                        o_avm_readdata <= {24'd0, rx_byte};
                        rx_idle        <= 0;
                    end else if (i_avm_address == STATUS_ADDR) begin
                        o_avm_readdata[RX_OK_BIT] <= (rx_q.size() != 0)
                                                     && (rx_idle >= int'(i_rx_delay));
                        o_avm_readdata[TX_OK_BIT] <= (tx_idle >= int'(i_tx_delay));
                    end
                end
            end
        end
    end

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // reset rises before the first edge and is held for two cycles
    initial begin
        o_rst <= 1'b0;
        #1 o_rst <= 1'b1;
        repeat (2) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== hdl/sw_wrapper.sv ====
`timescale 1ns/100ps

module sw_wrapper
    import sw_score_pkg::*;
    import avm_map_pkg::*;
#(
    parameter int REF_LEN  = 16,
    parameter int READ_LEN = 16
) (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  o_avm_address,
    output logic        o_avm_read,
    output logic        o_avm_write,
    input  logic [31:0] i_avm_readdata,
    output logic [31:0] o_avm_writedata,
    input  logic        i_avm_waitrequest
);

    localparam int REF_BYTES = REF_LEN / 4;
    localparam int IN_BYTES  = REF_BYTES + READ_LEN / 4;
    localparam int CNT_MAX   = (IN_BYTES > RESULT_BYTES) ? IN_BYTES : RESULT_BYTES;
    localparam int CNT_W     = $clog2(CNT_MAX);
    localparam int COL_W     = $clog2(REF_LEN);
    localparam int ROW_W     = $clog2(READ_LEN);

    wrap_state_e state_r;

    logic [CNT_W-1:0]          byte_cnt_r;
    logic [4:0]                address_r;
    logic                      read_r, write_r;
    logic                      core_valid_r;
    logic [2*REF_LEN-1:0]      seq_ref_r;
    logic [2*READ_LEN-1:0]     seq_read_r;
    logic [8*RESULT_BYTES-1:0] result_r;
    logic [7:0]                rx_byte;
    logic                      access_done;

    logic             core_ready, core_done, core_take;
    score_t           core_score;
    logic [ROW_W-1:0] core_row;
    logic [COL_W-1:0] core_col;

    assign o_avm_address   = address_r;
    assign o_avm_read      = read_r;
    assign o_avm_write     = write_r;
    assign o_avm_writedata = {24'd0, result_r[8*RESULT_BYTES-1 -: 8]};

    assign access_done = !i_avm_waitrequest;
    assign rx_byte     = i_avm_readdata[7:0];
    assign core_take   = (state_r == WR_CALC);

    sw_core #(
        .REF_LEN  (REF_LEN),
        .READ_LEN (READ_LEN)
    ) u_core (
        .i_clk      (avm_clk),
        .i_rst      (avm_rst),
        .i_valid    (core_valid_r),
        .o_ready    (core_ready),
        .i_seq_ref  (seq_ref_r),
        .i_seq_read (seq_read_r),
        .o_valid    (core_done),
        .i_ready    (core_take),
        .o_score    (core_score),
        .o_row      (core_row),
        .o_column   (core_col)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r      <= WR_POLL_RX;
            byte_cnt_r   <= '0;
            address_r    <= STATUS_ADDR;
            read_r       <= 1'b1;
            write_r      <= 1'b0;
            core_valid_r <= 1'b0;
        end else begin
            case (state_r)
                WR_POLL_RX: begin
                    if (access_done && i_avm_readdata[RX_OK_BIT]) begin
                        address_r <= RX_ADDR;
                        state_r   <= WR_READ;
                    end
                end
                WR_READ: begin
                    if (access_done) begin
                        if (byte_cnt_r == CNT_W'(IN_BYTES - 1)) begin
                            byte_cnt_r   <= '0;
                            read_r       <= 1'b0;
                            core_valid_r <= 1'b1;
                            state_r      <= WR_CALC;
                        end else begin
                            byte_cnt_r <= byte_cnt_r + 1'b1;
                            address_r  <= STATUS_ADDR;
                            state_r    <= WR_POLL_RX;
                        end
                    end
                end
                WR_CALC: begin
                    if (core_valid_r && core_ready)
                        core_valid_r <= 1'b0;
                    if (core_done) begin
                        read_r    <= 1'b1;
                        address_r <= STATUS_ADDR;
                        state_r   <= WR_POLL_TX;
                    end
                end
                WR_POLL_TX: begin
                    if (access_done && i_avm_readdata[TX_OK_BIT]) begin
                        read_r    <= 1'b0;
                        write_r   <= 1'b1;
                        address_r <= TX_ADDR;
                        state_r   <= WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    if (access_done) begin
                        write_r   <= 1'b0;
                        read_r    <= 1'b1;
                        address_r <= STATUS_ADDR;
                        if (byte_cnt_r == CNT_W'(RESULT_BYTES - 1)) begin
                            byte_cnt_r <= '0;
                            state_r    <= WR_POLL_RX;
                        end else begin
                            byte_cnt_r <= byte_cnt_r + 1'b1;
                            state_r    <= WR_POLL_TX;
                        end
                    end
                end
                default: state_r <= WR_POLL_RX;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        // reference bytes arrive first, then the read
        if (state_r == WR_READ && access_done) begin
            if (byte_cnt_r < CNT_W'(REF_BYTES))
                seq_ref_r <= (2*REF_LEN)'({seq_ref_r, rx_byte});
            else
                seq_read_r <= (2*READ_LEN)'({seq_read_r, rx_byte});
        end
        // score high, score low, row, column
        if (state_r == WR_CALC && core_done)
            result_r <= {{(16 - SCORE_W){core_score[SCORE_W-1]}}, core_score,
                         8'(core_row), 8'(core_col)};
        else if (state_r == WR_WRITE && access_done)
            result_r <= result_r << 8;
    end

endmodule

// ==== hdl/sw_core.sv ====
`timescale 1ns/100ps

module sw_core
    import sw_score_pkg::*;
#(
    parameter int REF_LEN  = 16,
    parameter int READ_LEN = 16
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_valid,
    output logic                        o_ready,
    input  logic [2*REF_LEN-1:0]        i_seq_ref,
    input  logic [2*READ_LEN-1:0]       i_seq_read,
    output logic                        o_valid,
    input  logic                        i_ready,
    output score_t                      o_score,
    output logic [$clog2(READ_LEN)-1:0] o_row,
    output logic [$clog2(REF_LEN)-1:0]  o_column
);

    localparam int COL_W = $clog2(REF_LEN);
    localparam int ROW_W = $clog2(READ_LEN);

    core_state_e state_r;

    logic [2*REF_LEN-1:0]  seq_ref_r;
    logic [2*READ_LEN-1:0] seq_read_r;
    logic [COL_W-1:0]      col_r, ref_idx, best_col_r;
    logic [ROW_W-1:0]      row_r, read_idx, best_row_r;

    // previous row of H and F, indexed by column
    score_t h_row [REF_LEN];
    score_t f_row [REF_LEN];

    score_t h_left_r, e_left_r, diag_r, best_r;
    score_t h_diag, h_up, h_left, e_left, f_up;
    score_t cell_h, cell_e, cell_f;

    logic [1:0] base_ref, base_read;
    logic       accept, fill;
    logic       first_row, first_col, last_row, last_col;

    assign o_ready = (state_r == CORE_IDLE);
    assign o_valid = (state_r == CORE_DONE);
    assign accept  = o_ready && i_valid;
    assign fill    = (state_r == CORE_FILL);

    assign first_row = (row_r == '0);
    assign first_col = (col_r == '0);
    assign last_row  = (row_r == ROW_W'(READ_LEN - 1));
    assign last_col  = (col_r == COL_W'(REF_LEN - 1));

    // first base sits in the top bit pair
    assign ref_idx   = COL_W'(REF_LEN - 1) - col_r;
    assign read_idx  = ROW_W'(READ_LEN - 1) - row_r;
    assign base_ref  = seq_ref_r[{ref_idx, 1'b0} +: 2];
    assign base_read = seq_read_r[{read_idx, 1'b0} +: 2];

    // H is zero on the matrix border and gap scores start at the floor
    assign h_up   = first_row ? '0 : h_row[col_r];
    assign f_up   = first_row ? SCORE_MIN : f_row[col_r];
    assign h_left = first_col ? '0 : h_left_r;
    assign e_left = first_col ? SCORE_MIN : e_left_r;
    assign h_diag = (first_row || first_col) ? '0 : diag_r;

    sw_cell u_cell (
        .i_base_ref  (base_ref),
        .i_base_read (base_read),
        .i_h_diag    (h_diag),
        .i_h_up      (h_up),
        .i_h_left    (h_left),
        .i_e_left    (e_left),
        .i_f_up      (f_up),
        .o_h         (cell_h),
        .o_e         (cell_e),
        .o_f         (cell_f)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= CORE_IDLE;
            row_r   <= '0;
            col_r   <= '0;
        end else begin
            case (state_r)
                CORE_IDLE: begin
                    if (accept) begin
                        state_r <= CORE_FILL;
                        row_r   <= '0;
                        col_r   <= '0;
                    end
                end
                CORE_FILL: begin
                    if (last_col) begin
                        col_r <= '0;
                        row_r <= row_r + 1'b1;
                        if (last_row)
                            state_r <= CORE_DONE;
                    end else begin
                        col_r <= col_r + 1'b1;
                    end
                end
                CORE_DONE: begin
                    if (i_ready)
                        state_r <= CORE_IDLE;
                end
                default: state_r <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            seq_ref_r  <= i_seq_ref;
            seq_read_r <= i_seq_read;
            best_r     <= '0;
            best_row_r <= '0;
            best_col_r <= '0;
        end
        if (fill) begin
            h_row[col_r] <= cell_h;
            f_row[col_r] <= cell_f;
            diag_r       <= h_up;
            h_left_r     <= cell_h;
            e_left_r     <= cell_e;
            // strict compare keeps the first maximum in scan order
            if (cell_h > best_r) begin
                best_r     <= cell_h;
                best_row_r <= row_r;
                best_col_r <= col_r;
            end
        end
    end

    assign o_score  = best_r;
    assign o_row    = best_row_r;
    assign o_column = best_col_r;

endmodule

// ==== hdl/sw_cell.sv ====
`timescale 1ns/100ps

module sw_cell
    import sw_score_pkg::*;
(
    input  logic [1:0] i_base_ref,
    input  logic [1:0] i_base_read,
    input  score_t     i_h_diag,
    input  score_t     i_h_up,
    input  score_t     i_h_left,
    input  score_t     i_e_left,
    input  score_t     i_f_up,
    output score_t     o_h,
    output score_t     o_e,
    output score_t     o_f
);

    // two guard bits so the sums cannot wrap before clamping
    typedef logic signed [SCORE_W+1:0] wide_t;

    wide_t  e_open, e_ext, f_open, f_ext, diag_sum;
    score_t sub_score, e_sat, f_sat, diag_sat, h_best;

    function automatic score_t saturate(input wide_t v);
        if (v > SCORE_MAX)
            return SCORE_MAX;
        else if (v < SCORE_MIN)
            return SCORE_MIN;
        else
            return score_t'(v);
    endfunction

    assign sub_score = (i_base_ref == i_base_read) ? MATCH_SCORE : MISMATCH_SCORE;

    always_comb begin
        e_open   = wide_t'(i_h_left) + wide_t'(GAP_OPEN);
        e_ext    = wide_t'(i_e_left) + wide_t'(GAP_EXTEND);
        f_open   = wide_t'(i_h_up) + wide_t'(GAP_OPEN);
        f_ext    = wide_t'(i_f_up) + wide_t'(GAP_EXTEND);
        diag_sum = wide_t'(i_h_diag) + wide_t'(sub_score);

        e_sat    = saturate((e_open > e_ext) ? e_open : e_ext);
        f_sat    = saturate((f_open > f_ext) ? f_open : f_ext);
        diag_sat = saturate(diag_sum);

        // local alignment floor at zero
        h_best = '0;
        if (diag_sat > h_best)
            h_best = diag_sat;
        if (e_sat > h_best)
            h_best = e_sat;
        if (f_sat > h_best)
            h_best = f_sat;
    end

    assign o_h = h_best;
    assign o_e = e_sat;
    assign o_f = f_sat;

endmodule

// ==== hdl/avm_map_pkg.sv ====
package avm_map_pkg;

    localparam logic [4:0] RX_ADDR     = 5'd0;
    localparam logic [4:0] TX_ADDR     = 5'd4;
    localparam logic [4:0] STATUS_ADDR = 5'd8;

    localparam int TX_OK_BIT    = 6;
    localparam int RX_OK_BIT    = 7;
    localparam int RESULT_BYTES = 4;

    typedef enum logic [2:0] {
        WR_POLL_RX,
        WR_READ,
        WR_CALC,
        WR_POLL_TX,
        WR_WRITE
    } wrap_state_e;

endpackage

// ==== hdl/sw_score_pkg.sv ====
package sw_score_pkg;

    localparam int SCORE_W = 10;

    typedef logic signed [SCORE_W-1:0] score_t;

    // saturation limits of the score range
    localparam score_t SCORE_MAX = score_t'(2 ** (SCORE_W - 1) - 1);
    localparam score_t SCORE_MIN = score_t'(-(2 ** (SCORE_W - 1)));

    localparam score_t MATCH_SCORE    = 1;
    localparam score_t MISMATCH_SCORE = -4;
    localparam score_t GAP_OPEN       = -6;
    localparam score_t GAP_EXTEND     = -1;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_FILL,
        CORE_DONE
    } core_state_e;

endpackage
